// ==== arb_pkg.sv ====
// Shared types and limits for the request arbiter and data path.
// Modules take what they need through a wildcard import in their header.
package arb_pkg;

    // Largest number of requesters supported by the index width
    localparam int MAX_PORTS = 16;

    // Width of one requester data word
    localparam int DATA_W = 16;

    // Requester index, sized for MAX_PORTS
    typedef logic [3:0] port_idx_t;

    // One requester data word
    typedef logic [DATA_W-1:0] data_t;

    // Registered output of the data path
    typedef struct packed {
        logic      valid;  // Word carries a granted request
        port_idx_t src;    // Index of the granted requester
        data_t     data;   // Word presented by that requester
    } sel_word_t;

endpackage

// ==== priority_encoder.sv ====
// Combinational priority encoder, highest set bit wins.
// Reports whether any bit is set, its index and a one-hot mask of it.
// Shared by the raw and masked search paths of the arbiter.
`timescale 1ns/1ns

module priority_encoder import arb_pkg::*; #(
    parameter int WIDTH = 4
) (
    input  logic [WIDTH-1:0] unencoded,  // Request bits to scan
    output logic             valid,      // Any bit set
    output port_idx_t        encoded,    // Index of winning bit
    output logic [WIDTH-1:0] onehot      // Winning bit alone
);

    always_comb begin
        valid   = 1'b0;
        encoded = '0;
        onehot  = '0;

        // Ascending scan, a later hit overrides so the top bit wins
        for (int i = 0; i < WIDTH; i++) begin
            if (unencoded[i]) begin
                valid     = 1'b1;
                encoded   = port_idx_t'(i);
                onehot    = '0;  // Drop any lower hit
                onehot[i] = 1'b1;
            end
        end
    end

endmodule

// ==== arbiter.sv ====
// Registered request arbiter with priority and round-robin search.
// rr_mode picks round robin, hold_mode keeps a grant while its request stays high.
// Both are static levels, change them only with all requests low.
// Grant outputs follow request by one clock.
`timescale 1ns/1ns

module arbiter import arb_pkg::*; #(
    parameter int PORTS = 5
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             rr_mode,      // Round-robin search when high
    input  logic             hold_mode,    // Block until granted request drops
    input  logic [PORTS-1:0] request,
    output logic [PORTS-1:0] grant,        // One-hot or zero
    output logic             grant_valid,
    output port_idx_t        grant_index
);

    logic [PORTS-1:0] mask_q;  // RR window, all bits below last grant
    logic [PORTS-1:0] mask_d;
    logic [PORTS-1:0] grant_d;
    logic             grant_valid_d;
    port_idx_t        grant_index_d;

    // Raw search over every request
    logic             raw_valid;
    port_idx_t        raw_index;
    logic [PORTS-1:0] raw_onehot;

    // Search restricted to the RR window
    logic             msk_valid;
    port_idx_t        msk_index;
    logic [PORTS-1:0] msk_onehot;

    logic hold;

    priority_encoder #(
        .WIDTH (PORTS)
    ) i_enc_raw (
        .unencoded (request),
        .valid     (raw_valid),
        .encoded   (raw_index),
        .onehot    (raw_onehot)
    );

    priority_encoder #(
        .WIDTH (PORTS)
    ) i_enc_masked (
        .unencoded (request & mask_q),
        .valid     (msk_valid),
        .encoded   (msk_index),
        .onehot    (msk_onehot)
    );

    // Current owner still asking
    assign hold = hold_mode && |(grant & request);

    always_comb begin
        grant_d       = '0;
        grant_valid_d = 1'b0;
        grant_index_d = '0;
        mask_d        = mask_q;  // Idle keeps the RR position

        if (hold) begin
            grant_d       = grant;
            grant_valid_d = grant_valid;
            grant_index_d = grant_index;
        end else if (raw_valid) begin
            grant_valid_d = 1'b1;
            if (rr_mode && msk_valid) begin
                grant_d       = msk_onehot;  // Next one down
                grant_index_d = msk_index;
            end else begin
                // Priority, or RR wrap back to the top
                grant_d       = raw_onehot;
                grant_index_d = raw_index;
            end
            mask_d = grant_d - 1'b1;  // Bits strictly below the new grant
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant       <= '0;
            grant_valid <= 1'b0;
            grant_index <= '0;
            mask_q      <= '0;
        end else begin
            grant       <= grant_d;
            grant_valid <= grant_valid_d;
            grant_index <= grant_index_d;
            mask_q      <= mask_d;
        end
    end

    // Build range for the index type
    a_ports_range: assert property (@(posedge clk) PORTS >= 2 && PORTS <= MAX_PORTS);

    a_grant_onehot0: assert property (@(posedge clk) disable iff (rst)
        $onehot0(grant));

    a_valid_matches: assert property (@(posedge clk) disable iff (rst)
        grant_valid == (grant != '0));

    // Encoded index names the granted bit
    a_index_matches: assert property (@(posedge clk) disable iff (rst)
        grant_valid |-> grant == (PORTS'(1) << grant_index));

endmodule

// ==== data_select.sv ====
// Output register of the shared data path.
// Captures the granted requester's word and index one clock after the grant
// and holds a zero payload while no grant is valid.
`timescale 1ns/1ns

module data_select import arb_pkg::*; #(
    parameter int PORTS = 5
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  grant_valid,
    input  port_idx_t             grant_index,
    input  data_t     [PORTS-1:0] req_data,   // One word per requester
    output sel_word_t             out_word
);

    sel_word_t word_d;

    always_comb begin
        word_d = '0;  // Idle word is all zero
        if (grant_valid) begin
            word_d.valid = 1'b1;
            word_d.src   = grant_index;
            word_d.data  = req_data[grant_index];  // Mux of the live word
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_word <= '0;
        end else begin
            out_word <= word_d;
        end
    end

    a_ports_range: assert property (@(posedge clk) PORTS >= 2 && PORTS <= MAX_PORTS);

    // Arbiter must never point past the last requester
    a_index_in_range: assert property (@(posedge clk) disable iff (rst)
        grant_valid |-> grant_index < PORTS);

endmodule

// ==== arb_mux_top.sv ====
// Arbitrated data path for PORTS requesters.
// Grant outputs follow request by one clock, out_word by two.
// out_word samples req_data one clock before it appears.
`timescale 1ns/1ns

module arb_mux_top import arb_pkg::*; #(
    parameter int PORTS = 5
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rr_mode,    // Static, round robin when high
    input  logic                  hold_mode,  // Static, hold grant while requested
    input  logic      [PORTS-1:0] request,
    input  data_t     [PORTS-1:0] req_data,
    output logic      [PORTS-1:0] grant,
    output logic                  grant_valid,
    output port_idx_t             grant_index,
    output sel_word_t             out_word
);

    arbiter #(
        .PORTS (PORTS)
    ) i_arbiter (
        .clk         (clk),
        .rst         (rst),
        .rr_mode     (rr_mode),
        .hold_mode   (hold_mode),
        .request     (request),
        .grant       (grant),
        .grant_valid (grant_valid),
        .grant_index (grant_index)
    );

    // Selector steers on the registered grant
    data_select #(
        .PORTS (PORTS)
    ) i_data_select (
        .clk         (clk),
        .rst         (rst),
        .grant_valid (grant_valid),
        .grant_index (grant_index),
        .req_data    (req_data),
        .out_word    (out_word)
    );

endmodule

// ==== arb_mux_checker.sv ====
// Checker for the arbitrated data path.
// Samples DUT ports on every rising edge and runs its own model of the
// grant rules, then compares grant outputs and the delayed output word.
// Exposes running check and error counts to the testbench top.
`timescale 1ns/1ns

module arb_mux_checker import arb_pkg::*; #(
    parameter int PORTS = 5
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rr_mode,
    input  logic                  hold_mode,
    input  logic      [PORTS-1:0] request,
    input  data_t     [PORTS-1:0] req_data,
    input  logic      [PORTS-1:0] grant,
    input  logic                  grant_valid,
    input  port_idx_t             grant_index,
    input  sel_word_t             out_word,
    output int                    checks,
    output int                    errors
);

    // Model state after an edge
    typedef struct packed {
        logic [PORTS-1:0] grant;
        logic             valid;
        port_idx_t        index;
        logic [PORTS-1:0] mask;   // Ports below the last grant
    } arb_state_t;

    arb_state_t model;
    sel_word_t  exp_word;  // Output word expected after the next edge

    initial begin
        checks   = 0;
        errors   = 0;
        model    = '0;
        exp_word = '0;
    end

    // Expected state one edge later, from the arbitration rules
    function automatic arb_state_t next_grant(input arb_state_t cur,
                                              input logic [PORTS-1:0] req,
                                              input logic rr,
                                              input logic hold);
        arb_state_t nxt;
        int         win;
        nxt = cur;
        win = -1;
        if (hold && (cur.grant & req) != '0) begin
            return cur;  // Owner still asking
        end
        if (rr) begin
            for (int i = PORTS - 1; i >= 0; i--) begin
                if (win < 0 && req[i] && cur.mask[i]) win = i;
            end
        end
        // Priority search, also the RR wrap to the top
        for (int i = PORTS - 1; i >= 0; i--) begin
            if (win < 0 && req[i]) win = i;
        end
        if (win < 0) begin
            nxt.grant = '0;   // Mask keeps its position
            nxt.valid = 1'b0;
            nxt.index = '0;
        end else begin
            nxt.grant      = '0;
            nxt.grant[win] = 1'b1;
            nxt.valid      = 1'b1;
            nxt.index      = port_idx_t'(win);
            nxt.mask       = '0;
            for (int j = 0; j < win; j++) nxt.mask[j] = 1'b1;
        end
        return nxt;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // All values seen here are the ones before the edge
    always @(posedge clk) begin
        if (rst) begin
            check("grant", '0, 32'(grant));
            check("grant_valid", '0, 32'(grant_valid));
            check("grant_index", '0, 32'(grant_index));
            check("out_word", '0, 32'(out_word));
            model    = '0;
            exp_word = '0;
        end else begin
            check("grant", 32'(model.grant), 32'(grant));
            check("grant_valid", 32'(model.valid), 32'(grant_valid));
            check("grant_index", 32'(model.index), 32'(grant_index));
            check("out_word", 32'(exp_word), 32'(out_word));

            // Word captured from the model grant and the live data
            exp_word = '0;
            if (model.valid) begin
                exp_word.valid = 1'b1;
                exp_word.src   = model.index;
                exp_word.data  = req_data[model.index];
            end
            model = next_grant(model, request, rr_mode, hold_mode);
        end
    end

endmodule

// ==== tb_arb_mux.sv ====
// Testbench top for the arbitrated data path with five requesters.
// Drives reset, mode levels, xorshift request patterns and data words.
// The checker module does all comparing and keeps the counts printed here.
`timescale 1ns/1ns

module tb_arb_mux import arb_pkg::*; ();

    localparam int PORTS   = 5;
    localparam int STEPS   = 60;   // Random patterns per test
    localparam int TIMEOUT = 20;   // Cycles allowed per wait

    logic                  clk;
    logic                  rst;
    logic                  rr_mode;
    logic                  hold_mode;
    logic      [PORTS-1:0] request;
    data_t     [PORTS-1:0] req_data;
    logic      [PORTS-1:0] grant;
    logic                  grant_valid;
    port_idx_t             grant_index;
    sel_word_t             out_word;
    int                    checks;
    int                    errors;
    int                    last_checks = 0;
    int                    last_errors = 0;
    logic [31:0]           rnd = 32'he7600088;

    arb_mux_top #(.PORTS(PORTS)) i_arb_mux_top (
        .clk (clk), .rst (rst), .rr_mode (rr_mode), .hold_mode (hold_mode),
        .request (request), .req_data (req_data), .grant (grant),
        .grant_valid (grant_valid), .grant_index (grant_index), .out_word (out_word)
    );

    arb_mux_checker #(.PORTS(PORTS)) i_checker (
        .clk (clk), .rst (rst), .rr_mode (rr_mode), .hold_mode (hold_mode),
        .request (request), .req_data (req_data), .grant (grant),
        .grant_valid (grant_valid), .grant_index (grant_index), .out_word (out_word),
        .checks (checks), .errors (errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic next_rand();
        rnd = xorshift32(rnd);
    endtask

    // New request pattern and fresh data on every port for one clock
    task automatic apply(input logic [PORTS-1:0] req);
        @(posedge clk);
        request <= req;
        for (int i = 0; i < PORTS; i++) begin
            next_rand();
            req_data[i] <= rnd[DATA_W-1:0];
        end
    endtask

    task automatic wait_grant();
        int n;
        n = 0;
        while (!grant_valid && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (!grant_valid) begin
            $display("Timeout, no grant after %0d cycles of active requests", TIMEOUT);
            $display("TB FAILED");
            $finish;
        end
    endtask

    // Grant and output word both drained
    task automatic wait_idle();
        int n;
        n = 0;
        while ((grant_valid || out_word.valid) && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (grant_valid || out_word.valid) begin
            $display("Timeout, path still busy %0d cycles after requests dropped", TIMEOUT);
            $display("TB FAILED");
            $finish;
        end
    endtask

    // Mode levels only move with all requests low
    task automatic set_modes(input logic rr, input logic hold);
        repeat (4) apply('0);
        wait_idle();
        @(posedge clk);
        rr_mode   <= rr;
        hold_mode <= hold;
        repeat (4) apply('0);
    endtask

    task automatic random_patterns();
        repeat (STEPS) begin
            next_rand();
            apply(rnd[PORTS-1:0]);
        end
    endtask

    // Owner keeps asking while random rivals come and go, then lets go
    task automatic hold_burst();
        logic [PORTS-1:0] req;
        logic [PORTS-1:0] owner;
        int               len;
        next_rand();
        req = rnd[PORTS-1:0];
        if (req == '0) req = PORTS'(1);
        repeat (3) apply(req);  // Grant now reflects req
        wait_grant();
        owner = grant;
        next_rand();
        len = 2 + int'(rnd[7:0] % 6);
        repeat (len) begin
            next_rand();
            apply(rnd[PORTS-1:0] | owner);
        end
        next_rand();
        apply(rnd[PORTS-1:0] & ~owner);
    endtask

    task automatic end_test(input string name);
        @(posedge clk);
        #1;  // Let the checker finish this edge
        $display("Test %-20s done: %0d checks, %0d errors",
                 name, checks - last_checks, errors - last_errors);
        last_checks = checks;
        last_errors = errors;
    endtask

    initial begin
        rst       <= 1'b1;
        rr_mode   <= 1'b0;
        hold_mode <= 1'b0;
        request   <= '0;
        req_data  <= '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (8) apply('0);
        end_test("reset and idle");

        set_modes(1'b0, 1'b0);
        random_patterns();
        end_test("priority random");

        set_modes(1'b1, 1'b0);
        apply('1);
        wait_grant();
        repeat (12) apply('1);  // Full rotation twice
        end_test("round robin all");
        random_patterns();
        end_test("round robin random");

        set_modes(1'b0, 1'b1);
        repeat (8) hold_burst();
        end_test("hold priority");
        set_modes(1'b1, 1'b1);
        repeat (8) hold_burst();
        end_test("hold round robin");

        set_modes(1'b0, 1'b0);
        end_test("final drain");

        $display("Summary: %0d passed, %0d failed", checks - errors, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
arb_pkg.sv
priority_encoder.sv
arbiter.sv
data_select.sv
arb_mux_top.sv
arb_mux_checker.sv
tb_arb_mux.sv

// ==== Bender.yml ====
package:
  name: arb_mux

sources:
  # Synthesizable design, package first
  - target: any(rtl, test)
    files:
      - arb_pkg.sv
      - priority_encoder.sv
      - arbiter.sv
      - data_select.sv
      - arb_mux_top.sv

  # Simulation only, top module tb_arb_mux
  - target: test
    files:
      - arb_mux_checker.sv
      - tb_arb_mux.sv
